// ==== src.f ====
hdl/mem_types_pkg.sv
hdl/axi_chan_pkg.sv
hdl/ready_enable_fifo.sv
hdl/axi_mem_reg_stage.sv
hdl/axi_mem_sram.sv
hdl/axi_mem_pipe_top.sv
dv/tb_axi_mem_pipe.sv

// ==== Makefile ====
# Verilator build and run for the memory request pipeline testbench
# Override on the command line, for example: make run N_STAGES=3

VERILATOR ?= verilator
TOP       ?= tb_axi_mem_pipe
N_STAGES  ?= 2
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GN_REG_STAGES=$(N_STAGES) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the simulation output holds the pass message
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_axi_mem_pipe.sv ====
`timescale 1ns/100ps

module tb_axi_mem_pipe
    import mem_types_pkg::*;
    import axi_chan_pkg::*;
#(
    parameter int N_REG_STAGES = 2
);

    localparam int MEM_DEPTH_LOG2 = 8;
    localparam int N_RAND = 300;

    // Directed tests issue 19 requests, the random test adds N_RAND more
    localparam int N_TXN = 19 + N_RAND;
    localparam int WDOG_CYCLES = N_TXN * (4 * N_REG_STAGES + 20);

    logic clk;
    logic reset;
    logic awvalid;
    aw_t  aw;
    logic awready;
    logic wvalid;
    w_t   w;
    logic wready;
    logic bvalid;
    b_t   b;
    logic bready;
    logic arvalid;
    ar_t  ar;
    logic arready;
    logic rvalid;
    r_t   r;
    logic rready;

    // Reference memory that holds an entry only for addresses that were written
    data_t ref_mem [addr_t];

    // Expected responses in request order
    b_t exp_b_q [$];
    r_t exp_r_q [$];
    b_t exp_b_head;
    r_t exp_r_head;

    string cur_test;
    int    err_count;
    int    test_err_start;
    int    tests_passed;
    int    tests_failed;
    logic  throttle;

    axi_mem_pipe_top #(
        .N_REG_STAGES   (N_REG_STAGES),
        .MEM_DEPTH_LOG2 (MEM_DEPTH_LOG2)
    ) i_dut (
        .clk     (clk),
        .reset   (reset),
        .awvalid (awvalid),
        .aw      (aw),
        .awready (awready),
        .wvalid  (wvalid),
        .w       (w),
        .wready  (wready),
        .bvalid  (bvalid),
        .b       (b),
        .bready  (bready),
        .arvalid (arvalid),
        .ar      (ar),
        .arready (arready),
        .rvalid  (rvalid),
        .r       (r),
        .rready  (rready)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Expected response of one access; a write also updates the model
    function automatic r_t ref_access(input logic is_wr, input id_t id, input addr_t addr,
                                      input strb_t strb, input data_t data);
        r_t    res;
        data_t word;
        res.id = id;
        if (addr >= addr_t'(1 << MEM_DEPTH_LOG2))
        begin
            // Out of range touches nothing and reads as zero
            res.resp = RESP_SLVERR;
            res.data = '0;
        end
        else
        begin
            word = ref_mem.exists(addr) ? ref_mem[addr] : '0;
            if (is_wr)
            begin
                for (int i = 0; i < DATA_W/8; i++)
                begin
                    if (strb[i])
                        word[8*i +: 8] = data[8*i +: 8];
                end
                ref_mem[addr] = word;
            end
            res.resp = RESP_OKAY;
            res.data = word;
        end
        return res;
    endfunction

    // Tasks below are entered and left 1 ns after a rising edge
    task automatic write_req(input id_t id, input addr_t addr, input strb_t strb,
                             input data_t data);
        r_t   res;
        b_t   exp_b;
        logic aw_fire;
        logic w_fire;
        res = ref_access(1'b1, id, addr, strb, data);
        exp_b.id = res.id;
        exp_b.resp = res.resp;
        exp_b_q.push_back(exp_b);
        awvalid = 1'b1;
        aw = '{id: id, addr: addr};
        wvalid = 1'b1;
        w = '{data: data, strb: strb};
        // AW and W may be accepted on different edges
        while (awvalid || wvalid)
        begin
            @(negedge clk);
            aw_fire = awvalid && awready;
            w_fire = wvalid && wready;
            @(posedge clk);
            #1;
            if (aw_fire)
                awvalid = 1'b0;
            if (w_fire)
                wvalid = 1'b0;
        end
    endtask

    task automatic read_req(input id_t id, input addr_t addr);
        logic ar_fire;
        exp_r_q.push_back(ref_access(1'b0, id, addr, '0, '0));
        arvalid = 1'b1;
        ar = '{id: id, addr: addr};
        while (arvalid)
        begin
            @(negedge clk);
            ar_fire = arready;
            @(posedge clk);
            #1;
            if (ar_fire)
                arvalid = 1'b0;
        end
    endtask

    // Wait until every outstanding response has come back
    task automatic drain();
        while (exp_b_q.size() != 0 || exp_r_q.size() != 0)
            @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_err_start = err_count;
    endtask

    task automatic end_test();
        int errs;
        drain();
        errs = err_count - test_err_start;
        if (errs == 0)
            tests_passed++;
        else
            tests_failed++;
        $display("test %-14s %s, %0d errors", cur_test, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    // Responses are sampled mid-cycle and transfer on the next rising edge
    always @(negedge clk)
    begin
        if (!reset && bvalid && bready)
        begin
            assert (exp_b_q.size() > 0)
            else
            begin
                $display("B response with no write outstanding in test %s", cur_test);
                err_count++;
            end
            if (exp_b_q.size() > 0)
            begin
                exp_b_head = exp_b_q.pop_front();
                assert (b === exp_b_head)
                else
                begin
                    $display("MISMATCH %s B expected %h actual %h", cur_test, exp_b_head, b);
                    err_count++;
                end
            end
        end
        if (!reset && rvalid && rready)
        begin
            assert (exp_r_q.size() > 0)
            else
            begin
                $display("R response with no read outstanding in test %s", cur_test);
                err_count++;
            end
            if (exp_r_q.size() > 0)
            begin
                exp_r_head = exp_r_q.pop_front();
                assert (r === exp_r_head)
                else
                begin
                    $display("MISMATCH %s R expected %h actual %h", cur_test, exp_r_head, r);
                    err_count++;
                end
            end
        end
    end

    // Response back-pressure is random only while throttling is on
    initial
    begin
        bready = 1'b1;
        rready = 1'b1;
        forever
        begin
            @(posedge clk);
            #1;
            bready = throttle ? ($urandom_range(3) != 0) : 1'b1;
            rready = throttle ? ($urandom_range(3) != 0) : 1'b1;
        end
    end

    initial
    begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, responses stopped arriving", WDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        addr_t addr;
        logic  is_wr;
        strb_t strb;
        logic  touched [addr_t];
        void'($urandom(39196));
        reset = 1'b1;
        awvalid = 1'b0;
        aw = '0;
        wvalid = 1'b0;
        w = '0;
        arvalid = 1'b0;
        ar = '0;
        throttle = 1'b0;
        err_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        begin_test("reset_state");
        @(negedge clk);
        assert (!bvalid && !rvalid)
        else
        begin
            $display("bvalid or rvalid is high right after reset");
            err_count++;
        end
        assert (awready && wready && arready)
        else
        begin
            $display("a request ready is low right after reset");
            err_count++;
        end
        @(posedge clk);
        #1;
        end_test();

        begin_test("write_read");
        write_req(4'h3, 16'h0010, 4'hF, 32'hDEAD_BEEF);
        drain();
        read_req(4'h5, 16'h0010);
        end_test();

        // Lanes 0 and 2 change, lanes 1 and 3 keep the earlier word
        begin_test("partial_strobe");
        write_req(4'h6, 16'h0010, 4'b0101, 32'h1122_3344);
        drain();
        read_req(4'h7, 16'h0010);
        end_test();

        // The out-of-range write aliases address 0x10 in its low bits
        begin_test("out_of_range");
        write_req(4'h8, addr_t'((1 << MEM_DEPTH_LOG2) | 16'h0010), 4'hF, 32'hCAFE_F00D);
        drain();
        read_req(4'h9, 16'hFFFF);
        read_req(4'hA, 16'h0010);
        end_test();

        begin_test("read_burst");
        for (int i = 0; i < 4; i++)
            write_req(id_t'(i), addr_t'(16'h0030 + i), 4'hF, data_t'(32'hA5A5_0000 + i * 257));
        drain();
        for (int i = 0; i < 8; i++)
            read_req(id_t'(i + 8), addr_t'(16'h0030 + i % 4));
        end_test();

        begin_test("random");
        throttle = 1'b1;
        for (int n = 0; n < N_RAND; n++)
        begin
            addr = ($urandom_range(7) == 0) ? addr_t'(16'hF000 + $urandom_range(3))
                                            : addr_t'(16'h0040 + $urandom_range(15));
            // A second access to one address waits for everything in flight
            if (touched.exists(addr))
            begin
                drain();
                touched.delete();
            end
            touched[addr] = 1'b1;
            is_wr = ($urandom_range(1) != 0);
            strb = strb_t'($urandom_range(15));
            // Unwritten words would read back unknown, so they get a full write first
            if ((addr >> MEM_DEPTH_LOG2) == '0 && !ref_mem.exists(addr))
            begin
                is_wr = 1'b1;
                strb = '1;
            end
            if (is_wr)
                write_req(id_t'($urandom_range(15)), addr, strb, data_t'($urandom));
            else
                read_req(id_t'($urandom_range(15)), addr);
        end
        end_test();
        throttle = 1'b0;

        $display("summary: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== hdl/axi_mem_pipe_top.sv ====
`timescale 1ns/100ps

module axi_mem_pipe_top
    import axi_chan_pkg::*;
#(
    parameter int N_REG_STAGES   = 2,
    parameter int MEM_DEPTH_LOG2 = 8
)
(
    input  logic clk,
    input  logic reset,

    input  logic awvalid,
    input  aw_t  aw,
    output logic awready,
    input  logic wvalid,
    input  w_t   w,
    output logic wready,
    output logic bvalid,
    output b_t   b,
    input  logic bready,
    input  logic arvalid,
    input  ar_t  ar,
    output logic arready,
    output logic rvalid,
    output r_t   r,
    input  logic rready
);

    // Index 0 is the port side and index N_REG_STAGES is the memory side
    logic p_awvalid [0:N_REG_STAGES];
    aw_t  p_aw      [0:N_REG_STAGES];
    logic p_awready [0:N_REG_STAGES];
    logic p_wvalid  [0:N_REG_STAGES];
    w_t   p_w       [0:N_REG_STAGES];
    logic p_wready  [0:N_REG_STAGES];
    logic p_bvalid  [0:N_REG_STAGES];
    b_t   p_b       [0:N_REG_STAGES];
    logic p_bready  [0:N_REG_STAGES];
    logic p_arvalid [0:N_REG_STAGES];
    ar_t  p_ar      [0:N_REG_STAGES];
    logic p_arready [0:N_REG_STAGES];
    logic p_rvalid  [0:N_REG_STAGES];
    r_t   p_r       [0:N_REG_STAGES];
    logic p_rready  [0:N_REG_STAGES];

    // The requester ports feed stage 1 directly
    assign p_awvalid[0] = awvalid;
    assign p_aw[0]      = aw;
    assign awready      = p_awready[0];
    assign p_wvalid[0]  = wvalid;
    assign p_w[0]       = w;
    assign wready       = p_wready[0];
    assign bvalid       = p_bvalid[0];
    assign b            = p_b[0];
    assign p_bready[0]  = bready;
    assign p_arvalid[0] = arvalid;
    assign p_ar[0]      = ar;
    assign arready      = p_arready[0];
    assign rvalid       = p_rvalid[0];
    assign r            = p_r[0];
    assign p_rready[0]  = rready;

    generate
        if (N_REG_STAGES < 1)
        begin : bad_cfg
            $error("N_REG_STAGES must be at least 1");
        end

        // Stage s sits between index s-1 and index s
        for (genvar s = 1; s <= N_REG_STAGES; s++)
        begin : stage
            axi_mem_reg_stage i_stage (
                .clk        (clk),
                .reset      (reset),
                .up_awvalid (p_awvalid[s-1]),
                .up_aw      (p_aw[s-1]),
                .up_awready (p_awready[s-1]),
                .up_wvalid  (p_wvalid[s-1]),
                .up_w       (p_w[s-1]),
                .up_wready  (p_wready[s-1]),
                .up_arvalid (p_arvalid[s-1]),
                .up_ar      (p_ar[s-1]),
                .up_arready (p_arready[s-1]),
                .up_bvalid  (p_bvalid[s-1]),
                .up_b       (p_b[s-1]),
                .up_bready  (p_bready[s-1]),
                .up_rvalid  (p_rvalid[s-1]),
                .up_r       (p_r[s-1]),
                .up_rready  (p_rready[s-1]),
                .dn_awvalid (p_awvalid[s]),
                .dn_aw      (p_aw[s]),
                .dn_awready (p_awready[s]),
                .dn_wvalid  (p_wvalid[s]),
                .dn_w       (p_w[s]),
                .dn_wready  (p_wready[s]),
                .dn_arvalid (p_arvalid[s]),
                .dn_ar      (p_ar[s]),
                .dn_arready (p_arready[s]),
                .dn_bvalid  (p_bvalid[s]),
                .dn_b       (p_b[s]),
                .dn_bready  (p_bready[s]),
                .dn_rvalid  (p_rvalid[s]),
                .dn_r       (p_r[s]),
                .dn_rready  (p_rready[s])
            );
        end
    endgenerate

    // The last stage drains into the memory
    axi_mem_sram #(.MEM_DEPTH_LOG2(MEM_DEPTH_LOG2)) sram (
        .clk     (clk),
        .reset   (reset),
        .awvalid (p_awvalid[N_REG_STAGES]),
        .aw      (p_aw[N_REG_STAGES]),
        .awready (p_awready[N_REG_STAGES]),
        .wvalid  (p_wvalid[N_REG_STAGES]),
        .w       (p_w[N_REG_STAGES]),
        .wready  (p_wready[N_REG_STAGES]),
        .bvalid  (p_bvalid[N_REG_STAGES]),
        .b       (p_b[N_REG_STAGES]),
        .bready  (p_bready[N_REG_STAGES]),
        .arvalid (p_arvalid[N_REG_STAGES]),
        .ar      (p_ar[N_REG_STAGES]),
        .arready (p_arready[N_REG_STAGES]),
        .rvalid  (p_rvalid[N_REG_STAGES]),
        .r       (p_r[N_REG_STAGES]),
        .rready  (p_rready[N_REG_STAGES])
    );

endmodule

// ==== hdl/axi_mem_sram.sv ====
`timescale 1ns/100ps

module axi_mem_sram
    import mem_types_pkg::*;
    import axi_chan_pkg::*;
#(
    parameter int MEM_DEPTH_LOG2 = 8
)
(
    input  logic clk,
    input  logic reset,

    input  logic awvalid,
    input  aw_t  aw,
    output logic awready,
    input  logic wvalid,
    input  w_t   w,
    output logic wready,
    output logic bvalid,
    output b_t   b,
    input  logic bready,

    input  logic arvalid,
    input  ar_t  ar,
    output logic arready,
    output logic rvalid,
    output r_t   r,
    input  logic rready
);

    localparam int MEM_DEPTH = 1 << MEM_DEPTH_LOG2;

    data_t mem [0:MEM_DEPTH-1];

    // AW or W that arrived ahead of its partner waits here
    logic aw_held;
    logic w_held;
    aw_t  aw_q;
    w_t   w_q;

    logic  aw_fire;
    logic  w_fire;
    logic  do_write;
    aw_t   aw_cur;
    w_t    w_cur;
    logic  wr_in_range;
    logic  rd_fire;
    logic  rd_in_range;

    // Readies come from registers only; a waiting response blocks new requests
    assign awready = !aw_held && !bvalid;
    assign wready  = !w_held && !bvalid;
    assign arready = !rvalid;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign rd_fire = arvalid && arready;

    // The write goes ahead once both halves are present, held or arriving now
    assign do_write = (aw_held || aw_fire) && (w_held || w_fire);
    assign aw_cur   = aw_held ? aw_q : aw;
    assign w_cur    = w_held ? w_q : w;

    // Upper address bits beyond the depth must all be zero
    assign wr_in_range = ((aw_cur.addr >> MEM_DEPTH_LOG2) == '0);
    assign rd_in_range = ((ar.addr >> MEM_DEPTH_LOG2) == '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            if (do_write)
            begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
            end
            else
            begin
                aw_held <= aw_held || aw_fire;
                w_held  <= w_held || w_fire;
            end

            // Responses stay valid until the consumer takes them
            if (do_write)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;

            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // Storage, held halves and response payloads
    always_ff @(posedge clk)
    begin
        if (aw_fire)
            aw_q <= aw;
        if (w_fire)
            w_q <= w;

        if (do_write)
        begin
            // Out-of-range writes leave storage untouched
            if (wr_in_range)
            begin
                for (int i = 0; i < DATA_W/8; i++)
                begin
                    if (w_cur.strb[i])
                        mem[aw_cur.addr[MEM_DEPTH_LOG2-1:0]][8*i +: 8] <= w_cur.data[8*i +: 8];
                end
            end
            b.id   <= aw_cur.id;
            b.resp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
        end

        if (rd_fire)
        begin
            r.id   <= ar.id;
            r.data <= rd_in_range ? mem[ar.addr[MEM_DEPTH_LOG2-1:0]] : '0;
            r.resp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Responses must hold under back-pressure until the handshake completes
    a_b_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(b));

    a_r_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(r));

endmodule

// ==== hdl/axi_mem_reg_stage.sv ====
`timescale 1ns/100ps

module axi_mem_reg_stage
    import axi_chan_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // Upstream side, toward the requester ports
    input  logic up_awvalid,
    input  aw_t  up_aw,
    output logic up_awready,
    input  logic up_wvalid,
    input  w_t   up_w,
    output logic up_wready,
    input  logic up_arvalid,
    input  ar_t  up_ar,
    output logic up_arready,
    output logic up_bvalid,
    output b_t   up_b,
    input  logic up_bready,
    output logic up_rvalid,
    output r_t   up_r,
    input  logic up_rready,

    // Downstream side, toward the memory
    output logic dn_awvalid,
    output aw_t  dn_aw,
    input  logic dn_awready,
    output logic dn_wvalid,
    output w_t   dn_w,
    input  logic dn_wready,
    output logic dn_arvalid,
    output ar_t  dn_ar,
    input  logic dn_arready,
    input  logic dn_bvalid,
    input  b_t   dn_b,
    output logic dn_bready,
    input  logic dn_rvalid,
    input  r_t   dn_r,
    output logic dn_rready
);

    // Each channel is registered on its own, so a stall on one never holds another

    // Request channels flow from up to down
    ready_enable_fifo #(.N_DATA_BITS($bits(aw_t))) aw (
        .clk             (clk),
        .reset           (reset),
        .enable_from_src (up_awvalid),
        .data_from_src   (up_aw),
        .ready_to_src    (up_awready),
        .enable_to_dst   (dn_awvalid),
        .data_to_dst     (dn_aw),
        .ready_from_dst  (dn_awready)
    );

    ready_enable_fifo #(.N_DATA_BITS($bits(w_t))) w (
        .clk             (clk),
        .reset           (reset),
        .enable_from_src (up_wvalid),
        .data_from_src   (up_w),
        .ready_to_src    (up_wready),
        .enable_to_dst   (dn_wvalid),
        .data_to_dst     (dn_w),
        .ready_from_dst  (dn_wready)
    );

    ready_enable_fifo #(.N_DATA_BITS($bits(ar_t))) ar (
        .clk             (clk),
        .reset           (reset),
        .enable_from_src (up_arvalid),
        .data_from_src   (up_ar),
        .ready_to_src    (up_arready),
        .enable_to_dst   (dn_arvalid),
        .data_to_dst     (dn_ar),
        .ready_from_dst  (dn_arready)
    );

    // Response channels flow from down to up
    ready_enable_fifo #(.N_DATA_BITS($bits(b_t))) b (
        .clk             (clk),
        .reset           (reset),
        .enable_from_src (dn_bvalid),
        .data_from_src   (dn_b),
        .ready_to_src    (dn_bready),
        .enable_to_dst   (up_bvalid),
        .data_to_dst     (up_b),
        .ready_from_dst  (up_bready)
    );

    ready_enable_fifo #(.N_DATA_BITS($bits(r_t))) r (
        .clk             (clk),
        .reset           (reset),
        .enable_from_src (dn_rvalid),
        .data_from_src   (dn_r),
        .ready_to_src    (dn_rready),
        .enable_to_dst   (up_rvalid),
        .data_to_dst     (up_r),
        .ready_from_dst  (up_rready)
    );

endmodule

// ==== hdl/ready_enable_fifo.sv ====
`timescale 1ns/100ps

module ready_enable_fifo #(
    parameter int N_DATA_BITS = 32
)
(
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   enable_from_src,
    input  logic [N_DATA_BITS-1:0] data_from_src,
    output logic                   ready_to_src,

    output logic                   enable_to_dst,
    output logic [N_DATA_BITS-1:0] data_to_dst,
    input  logic                   ready_from_dst
);

    // Entry 0 is always the oldest beat and drives the destination
    logic [N_DATA_BITS-1:0] entry0;
    logic [N_DATA_BITS-1:0] entry1;

    // Number of held beats, 0 to 2
    logic [1:0] count;

    logic push;
    logic pop;

    // Both handshake outputs come only from the fill count, so there is no
    // combinational path from ready_from_dst back to ready_to_src
    assign ready_to_src  = (count != 2'd2);
    assign enable_to_dst = (count != 2'd0);
    assign data_to_dst   = entry0;

    assign push = enable_from_src && ready_to_src;
    assign pop  = enable_to_dst && ready_from_dst;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= 2'd0;
        end
        else if (push && !pop)
        begin
            count <= count + 2'd1;
        end
        else if (pop && !push)
        begin
            count <= count - 2'd1;
        end
    end

    // Only the entries below the fill count hold live beats
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            // When full the second entry moves up, otherwise a beat arriving on
            // the same edge takes the head slot directly
            entry0 <= (count == 2'd2) ? entry1 : data_from_src;
        end
        else if (push)
        begin
            if (count == 2'd0)
            begin
                entry0 <= data_from_src;
            end
            else
            begin
                entry1 <= data_from_src;
            end
        end
    end

    // A source refused by a full buffer keeps offering the same beat
    a_full_src_hold: assert property (@(posedge clk) disable iff (reset)
        enable_from_src && !ready_to_src |=> enable_from_src && $stable(data_from_src));

    // A stalled output beat may not change or vanish before it is taken
    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        enable_to_dst && !ready_from_dst |=> enable_to_dst && $stable(data_to_dst));

endmodule

// ==== hdl/axi_chan_pkg.sv ====
package axi_chan_pkg;

    import mem_types_pkg::*;

    // Write address beat, single word, no burst fields
    typedef struct packed {
        id_t   id;
        addr_t addr;
    } aw_t;

    // Write data beat with its byte strobes
    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_t;

    // Write response, carries the ID of the write it answers
    typedef struct packed {
        id_t   id;
        resp_t resp;
    } b_t;

    // Read address beat
    typedef struct packed {
        id_t   id;
        addr_t addr;
    } ar_t;

    // Read data beat with the echoed ID and a response code
    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
    } r_t;

endpackage

// ==== hdl/mem_types_pkg.sv ====
package mem_types_pkg;

    // Word address width; the memory decodes only its low MEM_DEPTH_LOG2 bits
    localparam int ADDR_W = 16;

    // Data word width, a whole number of bytes
    localparam int DATA_W = 32;

    // Transaction tag width, echoed back on B and R
    localparam int ID_W = 4;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;

    // One strobe bit per byte lane of the data word
    typedef logic [DATA_W/8-1:0] strb_t;

    typedef logic [ID_W-1:0]     id_t;
    typedef logic [1:0]          resp_t;

    // AXI response codes used by the memory
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage
